// ==== source/ghash_config.svh ====
`ifndef GHASH_CONFIG_SVH
`define GHASH_CONFIG_SVH

// field element and H digit widths
`define GHASH_BLOCK_W       128
`define GHASH_DIGIT_W       32

// one pipeline stage per H digit
`define GHASH_STAGES        4

// message length limits, exponent fits the count width
`define GHASH_MAX_BLOCKS    7
`define GHASH_COUNT_W       3

// top byte of R = 11100001 || 0^120
`define GHASH_R_POLY        8'hE1

`endif

// ==== source/ghash_pkg.sv ====
`include "ghash_config.svh"

package ghash_pkg;

    // field element, bit 127 is the GCM x^0 coefficient
    typedef logic [`GHASH_BLOCK_W-1:0] block_t;

    // 32-bit slice of an H power
    typedef logic [`GHASH_DIGIT_W-1:0] digit_t;

    // exponent of H, also used for block counts
    typedef logic [`GHASH_COUNT_W-1:0] exp_t;

    // power of H applied by one pass
    typedef enum logic [1:0] {
        POW_1 = 2'd0,
        POW_2 = 2'd1,
        POW_4 = 2'd2
    } pow_sel_e;

    // travels alongside each item in the multiplier
    // pow: power for the pass in flight
    // rem: exponent still owed once this pass completes
    typedef struct packed {
        pow_sel_e pow;
        exp_t     rem;
    } mult_tag_t;

endpackage

// ==== source/ghash_mult_if.sv ====
interface ghash_mult_if;
    import ghash_pkg::*;

    // issue side
    logic      in_valid;
    block_t    in_data;
    mult_tag_t in_tag;

    // result side, last stage
    logic      out_valid;
    block_t    out_data;
    mult_tag_t out_tag;

    // one cycle ahead of the result side
    logic      near_valid;
    mult_tag_t near_tag;

    modport sched (
        output in_valid, in_data, in_tag,
        input  out_valid, out_data, out_tag,
        input  near_valid, near_tag
    );

    modport pipe (
        input  in_valid, in_data, in_tag,
        output out_valid, out_data, out_tag,
        output near_valid, near_tag
    );

endinterface

// ==== source/gf_mult_stage.sv ====
`include "ghash_config.svh"

module gf_mult_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid_i,
    input  ghash_pkg::block_t     z_i,
    input  ghash_pkg::block_t     v_i,
    input  ghash_pkg::mult_tag_t  tag_i,
    input  ghash_pkg::digit_t     digit_i,
    output logic                  out_valid_o,
    output ghash_pkg::block_t     z_o,
    output ghash_pkg::block_t     v_o,
    output ghash_pkg::mult_tag_t  tag_o
);
    import ghash_pkg::*;

    localparam block_t R_BLOCK = {`GHASH_R_POLY, {(`GHASH_BLOCK_W-8){1'b0}}};
    localparam bit     LAST    = (STAGE_IDX == `GHASH_STAGES-1);

    block_t z_next;
    block_t v_next;

    // shift-and-add over this digit, MSB first
    always_comb begin
        z_next = z_i;
        v_next = v_i;
        for (int i = `GHASH_DIGIT_W-1; i >= 0; i--) begin
            if (digit_i[i]) begin
                z_next = z_next ^ v_next;
            end
            // multiply V by x, fold x^128 back in
            if (v_next[0]) begin
                v_next = (v_next >> 1) ^ R_BLOCK;
            end else begin
                v_next = v_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
            tag_o       <= '0;
        end else begin
            out_valid_o <= in_valid_i;
            tag_o       <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        z_o <= z_next;
    end

    generate
        if (LAST) begin : g_no_v
            // V is dead after the final digit
            assign v_o = '0;
        end else begin : g_v
            always_ff @(posedge clk) begin
                v_o <= v_next;
            end
        end
    endgenerate

endmodule

// ==== source/gf_mult_pipe.sv ====
`include "ghash_config.svh"

module gf_mult_pipe (
    input  logic               clk,
    input  logic               rst,
    ghash_mult_if.pipe         mif,
    input  ghash_pkg::block_t  h1_i,
    input  ghash_pkg::block_t  h2_i,
    input  ghash_pkg::block_t  h4_i
);
    import ghash_pkg::*;

    localparam int NS = `GHASH_STAGES;
    localparam int DW = `GHASH_DIGIT_W;

    logic      valid_c [0:NS];
    block_t    z_c     [0:NS];
    mult_tag_t tag_c   [0:NS];
    block_t    v_c     [0:NS-1];
    digit_t    digit_c [0:NS-1];

    // every item enters with Z = 0, V = X
    assign valid_c[0] = mif.in_valid;
    assign z_c[0]     = '0;
    assign v_c[0]     = mif.in_data;
    assign tag_c[0]   = mif.in_tag;

    ////////////////////////////////////////////////////////////////////////////
    // digit stages
    ////////////////////////////////////////////////////////////////////////////
    for (genvar s = 0; s < NS; s++) begin : g_stage
        block_t h_sel;

        // power chosen per item, so mixed passes share the pipe
        always_comb begin
            case (tag_c[s].pow)
                POW_2:   h_sel = h2_i;
                POW_4:   h_sel = h4_i;
                default: h_sel = h1_i;
            endcase
        end

        assign digit_c[s] = h_sel[`GHASH_BLOCK_W-1-s*DW -: DW];

        if (s < NS-1) begin : g_mid
            gf_mult_stage #(.STAGE_IDX(s)) u_stage (
                .clk(clk), .rst(rst),
                .in_valid_i(valid_c[s]), .z_i(z_c[s]), .v_i(v_c[s]),
                .tag_i(tag_c[s]), .digit_i(digit_c[s]),
                .out_valid_o(valid_c[s+1]), .z_o(z_c[s+1]), .v_o(v_c[s+1]),
                .tag_o(tag_c[s+1])
            );
        end else begin : g_last
            gf_mult_stage #(.STAGE_IDX(s)) u_stage (
                .clk(clk), .rst(rst),
                .in_valid_i(valid_c[s]), .z_i(z_c[s]), .v_i(v_c[s]),
                .tag_i(tag_c[s]), .digit_i(digit_c[s]),
                .out_valid_o(valid_c[s+1]), .z_o(z_c[s+1]), .v_o(),
                .tag_o(tag_c[s+1])
            );
        end
    end

    assign mif.out_valid = valid_c[NS];
    assign mif.out_data  = z_c[NS];
    assign mif.out_tag   = tag_c[NS];

    // third stage output reaches the result side next cycle
    assign mif.near_valid = valid_c[NS-1];
    assign mif.near_tag   = tag_c[NS-1];

endmodule

// ==== source/ghash_sched.sv ====
module ghash_sched (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  ghash_pkg::exp_t    block_count_i,
    input  ghash_pkg::block_t  block_i,
    output logic               block_req_o,
    output logic               busy_o,
    output logic               done_o,
    output ghash_pkg::block_t  hash_o,
    ghash_mult_if.sched        mif
);
    import ghash_pkg::*;

    // exponent for the next block to fetch, 0 once all are requested
    exp_t   next_exp;
    // exponent of the block arriving this cycle
    exp_t   fetch_exp;
    logic   fetch_pend;
    // products still to be absorbed
    exp_t   prod_left;
    block_t acc;

    logic   start_ok;
    logic   recirc_now;
    logic   recirc_soon;
    logic   absorb;
    logic   absorb_last;

    // largest power first: 4, then 2, then 1
    function automatic mult_tag_t make_tag(exp_t e);
        mult_tag_t t;
        if (e[2]) begin
            t.pow = POW_4;
            t.rem = {1'b0, e[1:0]};
        end else if (e[1]) begin
            t.pow = POW_2;
            t.rem = {2'b00, e[0]};
        end else begin
            t.pow = POW_1;
            t.rem = '0;
        end
        return t;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // decisions
    ////////////////////////////////////////////////////////////////////////////

    // count of 0 does not start a message
    assign start_ok = start_i && !busy_o && (block_count_i != '0);

    // partial product coming out that still owes a power
    assign recirc_now  = mif.out_valid && (mif.out_tag.rem != '0);
    assign recirc_soon = mif.near_valid && (mif.near_tag.rem != '0);

    assign absorb      = mif.out_valid && (mif.out_tag.rem == '0);
    assign absorb_last = absorb && (prod_left == exp_t'(1));

    // only ask when the issue slot of the next cycle is free
    assign block_req_o = busy_o && (next_exp != '0) && !recirc_soon;

    ////////////////////////////////////////////////////////////////////////////
    // issue mux
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        mif.in_valid = 1'b0;
        mif.in_data  = '0;
        mif.in_tag   = '0;
        if (recirc_now) begin
            // feedback has priority, same cycle it leaves the last stage
            mif.in_valid = 1'b1;
            mif.in_data  = mif.out_data;
            mif.in_tag   = make_tag(mif.out_tag.rem);
        end else if (fetch_pend) begin
            mif.in_valid = 1'b1;
            mif.in_data  = block_i;
            mif.in_tag   = make_tag(fetch_exp);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // message state
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_o     <= 1'b0;
            done_o     <= 1'b0;
            fetch_pend <= 1'b0;
            next_exp   <= '0;
            prod_left  <= '0;
            acc        <= '0;
        end else begin
            done_o     <= absorb_last;
            fetch_pend <= block_req_o;

            // first block gets exponent n, last gets 1
            if (block_req_o) begin
                next_exp <= next_exp - 1'b1;
            end

            if (start_ok) begin
                busy_o    <= 1'b1;
                next_exp  <= block_count_i;
                prod_left <= block_count_i;
                acc       <= '0;
            end else if (absorb) begin
                // order of products does not matter, XOR commutes
                acc       <= acc ^ mif.out_data;
                prod_left <= prod_left - 1'b1;
                if (absorb_last) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_req_o) begin
            fetch_exp <= next_exp;
        end
    end

    // holds the last result until the next start
    assign hash_o = acc;

endmodule

// ==== source/ghash_top.sv ====
module ghash_top (
    input  logic               clk,
    input  logic               rst,

    // message
    input  logic               start_i,
    input  ghash_pkg::exp_t    block_count_i,
    input  ghash_pkg::block_t  block_i,
    output logic               block_req_o,

    // precomputed powers of H, stable while busy
    input  ghash_pkg::block_t  h1_i,
    input  ghash_pkg::block_t  h2_i,
    input  ghash_pkg::block_t  h4_i,

    // status and result
    output logic               busy_o,
    output logic               done_o,
    output ghash_pkg::block_t  hash_o
);

    ghash_mult_if u_mult_if ();

    ////////////////////////////////////////////////////////////////////////////
    // block fetch, pass issue and accumulation
    ////////////////////////////////////////////////////////////////////////////
    ghash_sched u_sched (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_i),
        .block_count_i (block_count_i),
        .block_i       (block_i),
        .block_req_o   (block_req_o),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .hash_o        (hash_o),
        .mif           (u_mult_if.sched)
    );

    ////////////////////////////////////////////////////////////////////////////
    // four-stage GF(2^128) multiplier
    ////////////////////////////////////////////////////////////////////////////
    gf_mult_pipe u_pipe (
        .clk  (clk),
        .rst  (rst),
        .mif  (u_mult_if.pipe),
        .h1_i (h1_i),
        .h2_i (h2_i),
        .h4_i (h4_i)
    );

endmodule

// ==== sim/ghash_checker.sv ====
module ghash_checker (
    input logic               clk,
    input logic               rst,
    input logic               busy_o,
    input logic               done_o,
    input logic               block_req_o,
    input ghash_pkg::block_t  hash_o
);
    import ghash_pkg::*;

    int unsigned assert_fails = 0;

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_o |=> !done_o)
        else begin
            assert_fails++;
            $error("done_o stayed high for more than one cycle");
        end

    // requested block arrives while the message is still open
    a_req_busy: assert property (@(posedge clk) disable iff (rst)
        block_req_o |=> busy_o)
        else begin
            assert_fails++;
            $error("busy_o low in the cycle a requested block arrives");
        end

    // a message only ends through done
    a_busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy_o) |-> done_o)
        else begin
            assert_fails++;
            $error("busy_o fell without done_o");
        end

    // result held between messages
    a_hash_hold: assert property (@(posedge clk) disable iff (rst)
        (!busy_o && !done_o) |-> $stable(hash_o))
        else begin
            assert_fails++;
            $error("hash_o changed while idle");
        end

endmodule

bind ghash_top ghash_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .block_req_o (block_req_o),
    .hash_o      (hash_o)
);

// ==== sim/ghash_tb.sv ====
`include "ghash_config.svh"

module ghash_tb;
    import ghash_pkg::*;

    localparam int     CLK_PERIOD  = 20;
    localparam int     MAXB        = `GHASH_MAX_BLOCKS;
    localparam int     N_MSGS      = 16;
    localparam int     CYC_PER_MSG = 60;
    localparam int     MARGIN_CYC  = 200;
    localparam block_t R_BLOCK     = {`GHASH_R_POLY, {(`GHASH_BLOCK_W-8){1'b0}}};

    // GCM test case 2: H, C and X1 = C*H
    localparam block_t KNOWN_H  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam block_t KNOWN_C  = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam block_t KNOWN_X1 = 128'h5e2ec746917062882c85b0685353deb7;

    logic   clk = 1'b0;
    logic   rst;
    logic   start;
    exp_t   block_count;
    block_t block;
    block_t h1, h2, h4;
    logic   block_req;
    logic   busy;
    logic   done;
    block_t hash;

    logic [31:0] lcg_state;
    block_t      msg_mem [0:MAXB-1];
    block_t      exp_hash;
    int          exp_n;
    int          blk_idx;
    int          req_count;
    int          done_seen;
    int          exp_dones;
    int          n_hash_err, n_count_err, n_flag_err, n_timeout;

    ghash_top u_ghash_top (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start),
        .block_count_i (block_count),
        .block_i       (block),
        .h1_i          (h1),
        .h2_i          (h2),
        .h4_i          (h4),
        .block_req_o   (block_req),
        .busy_o        (busy),
        .done_o        (done),
        .hash_o        (hash)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic block_t rand_block();
        block_t b;
        b = '0;
        for (int k = 0; k < 4; k++) begin
            b = {b[95:0], lcg_next()};
        end
        return b;
    endfunction

    // bit 127 holds x^0, shift right multiplies by x
    function automatic block_t gf_mul(input block_t x, input block_t y);
        block_t z;
        block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < `GHASH_BLOCK_W; i++) begin
            if (x[`GHASH_BLOCK_W-1-i]) begin
                z = z ^ v;
            end
            if (v[0]) begin
                v = (v >> 1) ^ R_BLOCK;
            end else begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    // XOR over i of X_i * H^(n-i+1)
    function automatic block_t ghash_ref(input block_t xs [0:MAXB-1], input int n,
                                         input block_t h);
        block_t acc;
        block_t hp;
        acc = '0;
        for (int i = 1; i <= n; i++) begin
            hp = h;
            for (int k = 1; k < n - i + 1; k++) begin
                hp = gf_mul(hp, h);
            end
            acc = acc ^ gf_mul(xs[i-1], hp);
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_hash(input block_t got, input block_t want, input string what);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, what, got, want);
            n_hash_err++;
        end
    endtask

    task automatic check_count(input exp_t got, input exp_t want, input string what);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s: got %0d expected %0d", $time, what, got, want);
            n_count_err++;
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s: got %b expected %b", $time, what, got, want);
            n_flag_err++;
        end
    endtask

    // block source, answers each request in the following cycle
    always begin
        @(negedge clk);
        if (!rst && block_req) begin
            req_count++;
            @(posedge clk);
            #2;
            if (blk_idx < MAXB) begin
                block = msg_mem[blk_idx];
            end else begin
                block = '0;
            end
            blk_idx++;
        end
    end

    // result comparison at every done pulse
    always @(negedge clk) begin
        if (!rst && done) begin
            check_hash(hash, exp_hash, "hash_o at done_o");
            check_count(exp_t'(req_count), exp_t'(exp_n), "block_req_o pulses");
            done_seen++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic set_h(input block_t h);
        h1 = h;
        h2 = gf_mul(h, h);
        h4 = gf_mul(h2, h2);
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            msg_mem[i] = rand_block();
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy_o while idle");
            check_flag(done, 1'b0, "done_o while idle");
            check_flag(block_req, 1'b0, "block_req_o while idle");
        end
    endtask

    task automatic begin_message(input int n);
        @(posedge clk);
        #2;
        exp_hash    = ghash_ref(msg_mem, n, h1);
        exp_n       = n;
        req_count   = 0;
        blk_idx     = 0;
        start       = 1'b1;
        block_count = exp_t'(n);
        @(posedge clk);
        #2;
        start       = 1'b0;
        block_count = '0;
    endtask

    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("timeout: done_o did not rise within %0d cycles at t=%0t", limit, $time);
            n_timeout++;
        end
    endtask

    // poke adds a start with another count while busy
    task automatic run_message(input int n, input bit poke);
        begin_message(n);
        exp_dones++;
        if (poke) begin
            repeat (2) @(posedge clk);
            #2;
            start       = 1'b1;
            block_count = exp_t'(2);
            @(posedge clk);
            #2;
            start       = 1'b0;
            block_count = '0;
        end
        wait_done(CYC_PER_MSG);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        block_t prev_hash;
        int     total;
        rst         = 1'b1;
        start       = 1'b0;
        block_count = '0;
        block       = '0;
        h1          = '0;
        h2          = '0;
        h4          = '0;
        lcg_state   = 32'd9424;
        exp_hash    = '0;
        exp_n       = 0;
        blk_idx     = 0;
        req_count   = 0;
        done_seen   = 0;
        exp_dones   = 0;
        n_hash_err  = 0;
        n_count_err = 0;
        n_flag_err  = 0;
        n_timeout   = 0;
        for (int i = 0; i < MAXB; i++) begin
            msg_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        check_idle(8);

        // single block against the published vector
        set_h(KNOWN_H);
        msg_mem[0] = KNOWN_C;
        run_message(1, 1'b0);
        check_hash(hash, KNOWN_X1, "one-block hash against test vector");
        check_idle(3);

        // every length with random data
        set_h(rand_block());
        for (int n = 1; n <= MAXB; n++) begin
            fill_random(n);
            run_message(n, 1'b0);
            check_idle(3);
        end

        // back to back, next start in the cycle after done
        set_h(rand_block());
        fill_random(7);
        run_message(7, 1'b0);
        fill_random(3);
        run_message(3, 1'b0);
        fill_random(1);
        run_message(1, 1'b0);
        fill_random(5);
        run_message(5, 1'b0);
        fill_random(2);
        run_message(2, 1'b0);
        check_idle(3);

        // start while busy, then a zero count while idle
        fill_random(4);
        run_message(4, 1'b1);
        prev_hash = hash;
        @(posedge clk);
        #2;
        req_count   = 0;
        start       = 1'b1;
        block_count = '0;
        @(posedge clk);
        #2;
        start       = 1'b0;
        check_idle(10);
        check_count(exp_t'(req_count), exp_t'(0), "requests after zero-count start");
        check_hash(hash, prev_hash, "hash_o after zero-count start");

        // reset in the middle of a message
        fill_random(7);
        begin_message(7);
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        check_idle(4);
        check_hash(hash, '0, "hash_o after reset");
        fill_random(6);
        run_message(6, 1'b0);

        repeat (4) @(posedge clk);
        if (done_seen != exp_dones) begin
            $display("done_o pulsed %0d times for %0d completed messages",
                     done_seen, exp_dones);
            n_flag_err++;
        end
        total = n_hash_err + n_count_err + n_flag_err + n_timeout
              + int'(u_ghash_top.u_checker.assert_fails);
        $display("errors: hash %0d, count %0d, flag %0d, timeout %0d, assertion %0d",
                 n_hash_err, n_count_err, n_flag_err, n_timeout,
                 u_ghash_top.u_checker.assert_fails);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog sized from the number of messages
    initial begin
        #((N_MSGS * CYC_PER_MSG + MARGIN_CYC) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/ghash_pkg.sv
source/ghash_mult_if.sv
source/gf_mult_stage.sv
source/gf_mult_pipe.sv
source/ghash_sched.sv
source/ghash_top.sv
sim/ghash_checker.sv
sim/ghash_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the GHASH testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=ghash_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module ghash_tb \
    -Mdir "${OBJ_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./${OBJ_DIR}/${SIM_BIN}" +verilator+error+limit+100 > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if grep -q "STATUS: FAIL" "${LOG_FILE}"; then
    exit 1
fi

if ! grep -q "STATUS: PASS" "${LOG_FILE}"; then
    echo "simulation log has no final status line"
    exit 1
fi

exit 0
